/* build.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_lsu_addr.sv
hdl/ex_stage.sv
test/ex_stage_checker.sv
test/ex_stage_tb.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vex_stage_tb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module ex_stage_tb -Mdir obj_dir

run: obj_dir/Vex_stage_tb
	@out="$$(./obj_dir/Vex_stage_tb)"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* test/ex_stage_tb.sv */
`default_nettype none

`include "ex_defines.svh"

module ex_stage_tb;

    logic            clk;
    logic            rst_n;
    logic            valid;
    logic            stall;
    ex_pkg::ex_req_t req;
    ex_pkg::ex_res_t res;
    ex_pkg::ex_res_t expected;
    integer          seed;
    int              issued;
    int              compared;
    int              checks;
    int              errors;
    int              timeouts;

    ex_stage u_dut (
        .clk     (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .valid_i (valid),
        .stall_i (stall),
        .res_o   (res)
    );

    bind ex_stage ex_stage_checker u_checker (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .stall_i (stall_i),
        .res_i   (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic ex_pkg::alu_sel_e sel_for(input ex_pkg::alu_op_e op);
        if (op >= ex_pkg::OP_OR && op <= ex_pkg::OP_NOR) return ex_pkg::SEL_LOGIC;
        if (op >= ex_pkg::OP_SLL && op <= ex_pkg::OP_SRA) return ex_pkg::SEL_SHIFT;
        if (op >= ex_pkg::OP_ADD && op <= ex_pkg::OP_TLTU) return ex_pkg::SEL_ARITH;
        if (op >= ex_pkg::OP_J && op <= ex_pkg::OP_BLTZAL) return ex_pkg::SEL_JUMP_BRANCH;
        if (op >= ex_pkg::OP_LB) return ex_pkg::SEL_LOAD_STORE;
        return ex_pkg::SEL_NONE;
    endfunction

    function automatic ex_pkg::ex_req_t build_req(input int k, input logic [31:0] a,
                                                  input logic [31:0] b, input logic [31:0] imm);
        ex_pkg::ex_req_t r;
        logic [31:0]     w;
        r      = '0;
        r.op   = ex_pkg::alu_op_e'(6'(k));
        r.sel  = sel_for(r.op);
        r.reg1 = a;
        r.reg2 = b;
        r.imm  = imm;
        w      = $random(seed);
        r.pc   = w & 32'hffff_fffc;
        w      = $random(seed);
        r.waddr       = w[4:0];
        r.we          = w[5] | w[6]; // mostly writing.
        r.pred_taken  = w[7];
        r.pred_target = $random(seed);
        return r;
    endfunction

    // expected result straight from the stage rules.
    function automatic ex_pkg::ex_res_t ex_model(input ex_pkg::ex_req_t r);
        ex_pkg::ex_res_t e;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     alu;
        logic [32:0]     wide;
        logic [31:0]     p4;
        logic [31:0]     addr;
        logic            jb;
        logic            ld;
        logic            st;
        logic            mis;
        e    = '0;
        a    = r.reg1;
        b    = r.reg2;
        alu  = '0;
        wide = {a[31], a} + {b[31], b};
        if (r.op == ex_pkg::OP_SUB || r.op == ex_pkg::OP_SUBU) wide = {a[31], a} - {b[31], b};
        case (r.op)
            ex_pkg::OP_OR:   alu = a | b;
            ex_pkg::OP_AND:  alu = a & b;
            ex_pkg::OP_XOR:  alu = a ^ b;
            ex_pkg::OP_NOR:  alu = ~(a | b);
            ex_pkg::OP_SLL:  alu = b << a[4:0];
            ex_pkg::OP_SRL:  alu = b >> a[4:0];
            ex_pkg::OP_SRA:  alu = $signed(b) >>> a[4:0];
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                alu = wide[31:0];
                e.exc.ovf = (r.op == ex_pkg::OP_ADD || r.op == ex_pkg::OP_SUB) &&
                            (wide[32] != wide[31]); // the extended sign disagrees.
            end
            ex_pkg::OP_SLT:  alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::OP_SLTU: alu = (a < b) ? 32'd1 : 32'd0;
            ex_pkg::OP_TEQ:  e.exc.trap = a == b;
            ex_pkg::OP_TNE:  e.exc.trap = a != b;
            ex_pkg::OP_TGE:  e.exc.trap = $signed(a) >= $signed(b);
            ex_pkg::OP_TGEU: e.exc.trap = a >= b;
            ex_pkg::OP_TLT:  e.exc.trap = $signed(a) < $signed(b);
            ex_pkg::OP_TLTU: e.exc.trap = a < b;
            default: ;
        endcase

        p4       = r.pc + 32'd4;
        jb       = 1'b1;
        e.br.npc = p4 + r.imm;
        case (r.op)
            ex_pkg::OP_J, ex_pkg::OP_JAL: begin
                e.br.taken = 1'b1;
                e.br.npc   = {p4[31:28], r.imm[27:0]};
            end
            ex_pkg::OP_JR, ex_pkg::OP_JALR: begin
                e.br.taken = 1'b1;
                e.br.npc   = a;
            end
            ex_pkg::OP_BEQ:  e.br.taken = a == b;
            ex_pkg::OP_BNE:  e.br.taken = a != b;
            ex_pkg::OP_BGTZ: e.br.taken = $signed(a) > 0;
            ex_pkg::OP_BLEZ: e.br.taken = $signed(a) <= 0;
            ex_pkg::OP_BGEZ, ex_pkg::OP_BGEZAL: e.br.taken = $signed(a) >= 0;
            ex_pkg::OP_BLTZ, ex_pkg::OP_BLTZAL: e.br.taken = $signed(a) < 0;
            default: begin
                jb       = 1'b0;
                e.br.npc = '0;
            end
        endcase
        e.br.mispredict = jb && ((r.pred_taken != e.br.taken) ||
                                 (e.br.taken && r.pred_target != e.br.npc));
        if (r.op inside {ex_pkg::OP_JAL, ex_pkg::OP_JALR, ex_pkg::OP_BGEZAL, ex_pkg::OP_BLTZAL})
            e.br.link = r.pc + 32'(`EX_LINK_OFFSET);

        addr = a + r.imm;
        ld   = r.op inside {ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_LH, ex_pkg::OP_LHU,
                            ex_pkg::OP_LW};
        st   = r.op inside {ex_pkg::OP_SB, ex_pkg::OP_SH, ex_pkg::OP_SW};
        mis  = 1'b0;
        case (r.op)
            ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_SB: e.mem.sel[addr[1:0]] = 1'b1;
            ex_pkg::OP_LH, ex_pkg::OP_LHU, ex_pkg::OP_SH: begin
                mis = addr[0];
                if (!mis) e.mem.sel = addr[1] ? 4'b1100 : 4'b0011;
            end
            ex_pkg::OP_LW, ex_pkg::OP_SW: begin
                mis = addr[1:0] != 2'b00;
                if (!mis) e.mem.sel = 4'b1111;
            end
            default: ;
        endcase
        if (r.op == ex_pkg::OP_SB) e.mem.wdata = {4{b[7:0]}};
        if (r.op == ex_pkg::OP_SH) e.mem.wdata = {2{b[15:0]}};
        if (r.op == ex_pkg::OP_SW) e.mem.wdata = b;
        if (ld || st) e.mem.addr = addr;
        e.exc.adel = ld & mis;
        e.exc.ades = st & mis;

        e.valid  = 1'b1;
        e.waddr  = r.waddr;
        e.we     = r.we & ~(|e.exc);
        e.mem.re = ld & ~(|e.exc);
        e.mem.we = st & ~(|e.exc);
        case (r.sel)
            ex_pkg::SEL_LOGIC, ex_pkg::SEL_SHIFT, ex_pkg::SEL_ARITH: e.wdata = alu;
            ex_pkg::SEL_JUMP_BRANCH: e.wdata = e.br.link;
            default: e.wdata = '0;
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_result(input ex_pkg::ex_res_t e);
        check_value("valid", 32'(res.valid), 32'(e.valid));
        check_value("waddr", 32'(res.waddr), 32'(e.waddr));
        check_value("we", 32'(res.we), 32'(e.we));
        check_value("wdata", res.wdata, e.wdata);
        check_value("br.taken", 32'(res.br.taken), 32'(e.br.taken));
        check_value("br.npc", res.br.npc, e.br.npc);
        check_value("br.mispredict", 32'(res.br.mispredict), 32'(e.br.mispredict));
        check_value("br.link", res.br.link, e.br.link);
        check_value("mem.re", 32'(res.mem.re), 32'(e.mem.re));
        check_value("mem.we", 32'(res.mem.we), 32'(e.mem.we));
        check_value("mem.addr", res.mem.addr, e.mem.addr);
        check_value("mem.sel", 32'(res.mem.sel), 32'(e.mem.sel));
        check_value("mem.wdata", res.mem.wdata, e.mem.wdata);
        check_value("exc.ovf", 32'(res.exc.ovf), 32'(e.exc.ovf));
        check_value("exc.trap", 32'(res.exc.trap), 32'(e.exc.trap));
        check_value("exc.adel", 32'(res.exc.adel), 32'(e.exc.adel));
        check_value("exc.ades", 32'(res.exc.ades), 32'(e.exc.ades));
    endtask

    // an instruction accepted at one edge is checked at the following falling edge.
    always begin
        @(posedge clk);
        if (rst_n && valid && !stall) begin
            expected = ex_model(req);
            @(negedge clk);
            compare_result(expected);
            compared++;
        end
    end

    task automatic send(input ex_pkg::ex_req_t r);
        req   = r;
        valid = 1'b1;
        stall = 1'b0;
        issued++;
        @(posedge clk);
        #1;
    endtask

    task automatic hold_during_stall(input int cycles);
        ex_pkg::ex_res_t held;
        held  = res;
        stall = 1'b1;
        req   = build_req(ex_pkg::OP_JAL, $random(seed), $random(seed), 32'd0);
        req.we         = 1'b1;
        req.pred_taken = 1'b0; // a taken jump guessed not taken would mispredict.
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            #1;
            check_value("stall hold", 32'(res == held), 32'd1);
        end
        stall = 1'b0;
        valid = 1'b0;
        @(posedge clk);
        #1;
        check_value("idle valid", 32'(res.valid), 32'd0);
        check_value("idle write", 32'(res.we), 32'd0);
        check_value("idle branch", 32'({res.br.taken, res.br.mispredict}), 32'd0);
        req = build_req(ex_pkg::OP_LW, 32'h0000_0100, $random(seed), 32'd0);
        @(posedge clk);
        #1;
        check_value("idle strobes", 32'({res.valid, res.mem.re, res.mem.we}), 32'd0);
    endtask

    task automatic wait_for_compares(input int limit);
        int cycles;
        cycles = 0;
        while (compared < issued && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (compared < issued) begin
            timeouts++;
            $display("timeout: only %0d of %0d results were compared", compared, issued);
        end
    endtask

    initial begin
        ex_pkg::ex_req_t r;
        ex_pkg::ex_res_t e;
        logic [31:0]     a;
        logic [31:0]     w;
        int              k;
        seed     = 64677;
        issued   = 0;
        compared = 0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        rst_n    = 1'b0;
        valid    = 1'b0;
        stall    = 1'b0;
        req      = '0;
        repeat (8) @(posedge clk);
        #1;
        check_value("reset", 32'(res == '0), 32'd1);
        rst_n = 1'b1;

        for (int i = 0; i < 40; i++) begin
            k = ex_pkg::OP_OR + int'($unsigned($random(seed)) % 13);
            send(build_req(k, $random(seed), $random(seed), 32'd0));
        end
        send(build_req(ex_pkg::OP_NOP, $random(seed), $random(seed), 32'd0));

        send(build_req(ex_pkg::OP_ADD, 32'h7fff_ffff, 32'd1, 32'd0));
        send(build_req(ex_pkg::OP_ADD, 32'h8000_0000, 32'hffff_ffff, 32'd0));
        send(build_req(ex_pkg::OP_SUB, 32'h8000_0000, 32'd1, 32'd0));
        send(build_req(ex_pkg::OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 32'd0));
        send(build_req(ex_pkg::OP_ADDU, 32'h7fff_ffff, 32'd1, 32'd0));
        send(build_req(ex_pkg::OP_ADDU, 32'h8000_0000, 32'hffff_ffff, 32'd0));

        for (k = ex_pkg::OP_TEQ; k <= ex_pkg::OP_TLTU; k++) begin
            send(build_req(k, 32'd5, 32'd5, 32'd0));
            send(build_req(k, 32'hffff_fffd, 32'd4, 32'd0));
            send(build_req(k, 32'd4, 32'hffff_fffd, 32'd0));
            send(build_req(k, 32'd1, 32'd2, 32'd0));
            send(build_req(k, 32'd2, 32'd1, 32'd0));
        end

        for (int i = 0; i < 48; i++) begin
            k = ex_pkg::OP_J + int'($unsigned($random(seed)) % 12);
            w = $random(seed);
            a = w[0] ? 32'd0 : $random(seed);
            r = build_req(k, a, w[1] ? a : $random(seed), w & 32'h0fff_fffc);
            e = ex_model(r);
            if (w[2]) r.pred_target = e.br.npc; // a right target half the time.
            send(r);
        end

        for (k = ex_pkg::OP_LB; k <= ex_pkg::OP_SW; k++) begin
            for (int ofs = 0; ofs < 4; ofs++) begin
                w = $random(seed);
                send(build_req(k, $random(seed) & 32'hffff_fffc, $random(seed),
                               (w & 32'h0000_0ffc) | 32'(ofs)));
            end
        end

        send(build_req(ex_pkg::OP_SLT, 32'hffff_fff0, 32'd3, 32'd0));
        hold_during_stall(5);

        wait_for_compares(50);
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/ex_stage_checker.sv */
`default_nettype none

module ex_stage_checker (
    input logic            clk,
    input logic            rst_n_i,
    input logic            valid_i,
    input logic            stall_i,
    input ex_pkg::ex_res_t res_i
);

    // an idle edge must not leave a result for the next stage.
    idle_clears_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!valid_i && !stall_i) |=> !res_i.valid)
        else $error("output valid stayed high after an idle edge");

    stall_holds_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(res_i))
        else $error("output bundle changed during a stall"); // the register is frozen.

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(res_i.mem.re && res_i.mem.we))
        else $error("read and write strobes high together");

    // a raised cause bit kills the write and both strobes.
    exception_gates: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|res_i.exc) |-> (!res_i.we && !res_i.mem.re && !res_i.mem.we))
        else $error("write or strobe left high with an exception");

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`default_nettype none

`include "ex_defines.svh"

module ex_stage (
    input  logic            clk,
    input  logic            rst_n_i,
    input  ex_pkg::ex_req_t req_i,
    input  logic            valid_i,
    input  logic            stall_i,
    output ex_pkg::ex_res_t res_o
);

    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_ovf;
    logic                alu_trap;
    ex_pkg::branch_res_t br;
    ex_pkg::mem_req_t    mem;
    logic                adel;
    logic                ades;
    ex_pkg::ex_exc_t     exc;
    logic                exc_any;
    logic [`EX_XLEN-1:0] wdata;
    ex_pkg::ex_res_t     res_d;

    ex_alu u_alu (
        .req_i    (req_i),
        .result_o (alu_result),
        .ovf_o    (alu_ovf),
        .trap_o   (alu_trap)
    );

    ex_branch_unit u_branch (
        .req_i (req_i),
        .br_o  (br)
    );

    ex_lsu_addr u_lsu (
        .req_i  (req_i),
        .mem_o  (mem),
        .adel_o (adel),
        .ades_o (ades)
    );

    assign exc = '{ovf: alu_ovf, trap: alu_trap, adel: adel, ades: ades};
    assign exc_any = |exc;

    always_comb begin
        case (req_i.sel)
            ex_pkg::SEL_LOGIC, ex_pkg::SEL_SHIFT, ex_pkg::SEL_ARITH: wdata = alu_result;
            ex_pkg::SEL_JUMP_BRANCH: wdata = br.link;
            ex_pkg::SEL_LOAD_STORE:  wdata = '0; // load data is written back after memory.
            default:                 wdata = '0;
        endcase
    end

    // any exception kills the write and both strobes but the cause bits travel on.
    always_comb begin
        res_d               = '0;
        res_d.valid         = valid_i;
        res_d.waddr         = req_i.waddr;
        res_d.we            = valid_i & req_i.we & ~exc_any;
        res_d.wdata         = wdata;
        res_d.br            = br;
        res_d.br.taken      = valid_i & br.taken;
        res_d.br.mispredict = valid_i & br.mispredict;
        res_d.mem           = mem;
        res_d.mem.re        = valid_i & mem.re & ~exc_any;
        res_d.mem.we        = valid_i & mem.we & ~exc_any;
        res_d.exc           = valid_i ? exc : '0;
    end

    // a stall holds the whole bundle so the next stage sees a stable result.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_o <= '0;
        end else if (!stall_i) begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_lsu_addr.sv */
`default_nettype none

`include "ex_defines.svh"

module ex_lsu_addr (
    input  ex_pkg::ex_req_t  req_i,
    output ex_pkg::mem_req_t mem_o,
    output logic             adel_o,
    output logic             ades_o
);

    logic [`EX_XLEN-1:0] addr;
    logic [1:0]          ofs;
    logic                is_load;
    logic                is_store;
    logic                misaligned;
    logic [3:0]          sel;
    logic [`EX_XLEN-1:0] wdata;

    assign addr = req_i.reg1 + req_i.imm;
    assign ofs  = addr[1:0];

    assign is_load  = req_i.op inside {ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_LH,
                                       ex_pkg::OP_LHU, ex_pkg::OP_LW};
    assign is_store = req_i.op inside {ex_pkg::OP_SB, ex_pkg::OP_SH, ex_pkg::OP_SW};

    always_comb begin
        misaligned = 1'b0;
        sel        = 4'b0000;
        case (req_i.op)
            ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_SB: begin
                sel = 4'b0001 << ofs;
            end
            ex_pkg::OP_LH, ex_pkg::OP_LHU, ex_pkg::OP_SH: begin
                misaligned = ofs[0];
                if (!ofs[0]) begin
                    sel = ofs[1] ? 4'b1100 : 4'b0011;
                end
            end
            ex_pkg::OP_LW, ex_pkg::OP_SW: begin
                misaligned = ofs != 2'b00;
                sel        = misaligned ? 4'b0000 : 4'b1111;
            end
            default: ;
        endcase
    end

    // the memory picks the lane through sel, so the data goes out on every lane.
    always_comb begin
        case (req_i.op)
            ex_pkg::OP_SB: wdata = {4{req_i.reg2[7:0]}};
            ex_pkg::OP_SH: wdata = {2{req_i.reg2[15:0]}};
            ex_pkg::OP_SW: wdata = req_i.reg2;
            default:       wdata = '0;
        endcase
    end

    always_comb begin
        mem_o.re    = is_load;
        mem_o.we    = is_store;
        mem_o.addr  = (is_load || is_store) ? addr : '0;
        mem_o.sel   = sel;
        mem_o.wdata = wdata;
    end

    assign adel_o = is_load & misaligned;
    assign ades_o = is_store & misaligned; // strobes are dropped in the stage top.

endmodule

`default_nettype wire

/* hdl/ex_branch_unit.sv */
`default_nettype none

`include "ex_defines.svh"

module ex_branch_unit (
    input  ex_pkg::ex_req_t     req_i,
    output ex_pkg::branch_res_t br_o
);

    logic [`EX_XLEN-1:0] pc_plus4;
    logic [`EX_XLEN-1:0] link_addr;
    logic [`EX_XLEN-1:0] br_target;
    logic                r1_neg;
    logic                r1_zero;
    logic                is_jb;
    logic                is_link;
    logic                taken;
    logic [`EX_XLEN-1:0] npc;

    assign pc_plus4  = req_i.pc + `EX_XLEN'(4);
    assign link_addr = req_i.pc + `EX_XLEN'(`EX_LINK_OFFSET);
    assign br_target = pc_plus4 + req_i.imm; // imm is already the shifted offset.

    assign r1_neg  = req_i.reg1[`EX_XLEN-1];
    assign r1_zero = req_i.reg1 == '0;

    assign is_link = req_i.op inside {ex_pkg::OP_JAL, ex_pkg::OP_JALR,
                                      ex_pkg::OP_BGEZAL, ex_pkg::OP_BLTZAL};

    // npc keeps the branch target even when a conditional branch falls through.
    always_comb begin
        is_jb = 1'b1;
        taken = 1'b0;
        npc   = br_target;
        case (req_i.op)
            ex_pkg::OP_J, ex_pkg::OP_JAL: begin
                taken = 1'b1;
                npc   = {pc_plus4[`EX_XLEN-1 -: 4], req_i.imm[`EX_XLEN-5:0]};
            end
            ex_pkg::OP_JR, ex_pkg::OP_JALR: begin
                taken = 1'b1;
                npc   = req_i.reg1;
            end
            ex_pkg::OP_BEQ:  taken = req_i.reg1 == req_i.reg2;
            ex_pkg::OP_BNE:  taken = req_i.reg1 != req_i.reg2;
            ex_pkg::OP_BGTZ: taken = ~r1_neg & ~r1_zero;
            ex_pkg::OP_BLEZ: taken = r1_neg | r1_zero;
            ex_pkg::OP_BGEZ, ex_pkg::OP_BGEZAL: taken = ~r1_neg;
            ex_pkg::OP_BLTZ, ex_pkg::OP_BLTZAL: taken = r1_neg;
            default: begin
                is_jb = 1'b0;
                npc   = '0;
            end
        endcase
    end

    always_comb begin
        br_o.taken = taken;
        br_o.npc   = npc;
        br_o.link  = is_link ? link_addr : '0;
        // a taken guess is only right if it also fetched the right target.
        br_o.mispredict = is_jb &&
                          ((req_i.pred_taken != taken) ||
                           (taken && req_i.pred_target != npc));
    end

endmodule

`default_nettype wire

/* hdl/ex_alu.sv */
`default_nettype none

`include "ex_defines.svh"

module ex_alu (
    input  ex_pkg::ex_req_t     req_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                ovf_o,
    output logic                trap_o
);

    logic                   sub;
    logic [`EX_XLEN-1:0]    operand_b;
    logic [`EX_XLEN-1:0]    sum;
    logic                   sign_a;
    logic                   sign_b;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [`EX_SHAMT_W-1:0] shamt;

    // the signed compares need the difference, not the sum.
    assign sub = req_i.op inside {ex_pkg::OP_SUB, ex_pkg::OP_SUBU, ex_pkg::OP_SLT,
                                  ex_pkg::OP_TGE, ex_pkg::OP_TLT};

    assign operand_b = sub ? ~req_i.reg2 : req_i.reg2;
    assign sum       = req_i.reg1 + operand_b + {{(`EX_XLEN-1){1'b0}}, sub};

    assign sign_a = req_i.reg1[`EX_XLEN-1];
    assign sign_b = req_i.reg2[`EX_XLEN-1];

    // differing signs decide at once, otherwise the difference cannot overflow.
    assign lt_signed   = (sign_a & ~sign_b) | (~(sign_a ^ sign_b) & sum[`EX_XLEN-1]);
    assign lt_unsigned = req_i.reg1 < req_i.reg2;

    assign shamt = req_i.reg1[`EX_SHAMT_W-1:0];

    always_comb begin
        case (req_i.op)
            ex_pkg::OP_OR:   result_o = req_i.reg1 | req_i.reg2;
            ex_pkg::OP_AND:  result_o = req_i.reg1 & req_i.reg2;
            ex_pkg::OP_XOR:  result_o = req_i.reg1 ^ req_i.reg2;
            ex_pkg::OP_NOR:  result_o = ~(req_i.reg1 | req_i.reg2);
            ex_pkg::OP_SLL:  result_o = req_i.reg2 << shamt;
            ex_pkg::OP_SRL:  result_o = req_i.reg2 >> shamt;
            ex_pkg::OP_SRA:  result_o = $signed(req_i.reg2) >>> shamt;
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                result_o = sum;
            end
            ex_pkg::OP_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ex_pkg::OP_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            default:         result_o = '0;
        endcase
    end

    // both addends share a sign and the result does not.
    assign ovf_o = (req_i.op == ex_pkg::OP_ADD || req_i.op == ex_pkg::OP_SUB) &&
                   (sign_a == operand_b[`EX_XLEN-1]) && (sum[`EX_XLEN-1] != sign_a);

    always_comb begin
        case (req_i.op)
            ex_pkg::OP_TEQ:  trap_o = req_i.reg1 == req_i.reg2;
            ex_pkg::OP_TNE:  trap_o = req_i.reg1 != req_i.reg2;
            ex_pkg::OP_TGE:  trap_o = ~lt_signed;
            ex_pkg::OP_TGEU: trap_o = ~lt_unsigned;
            ex_pkg::OP_TLT:  trap_o = lt_signed;
            ex_pkg::OP_TLTU: trap_o = lt_unsigned;
            default:         trap_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ex_pkg.sv */
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

    // immediate forms arrive already decoded into the register forms.
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_OR, OP_AND, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU,
        OP_J, OP_JAL, OP_JR, OP_JALR,
        OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
        OP_BGEZ, OP_BLTZ, OP_BGEZAL, OP_BLTZAL,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NONE        = 3'd0,
        SEL_LOGIC       = 3'd1,
        SEL_SHIFT       = 3'd2,
        SEL_ARITH       = 3'd3,
        SEL_JUMP_BRANCH = 3'd4,
        SEL_LOAD_STORE  = 3'd5
    } alu_sel_e;

    typedef struct packed {
        alu_op_e                op;
        alu_sel_e               sel;
        logic [`EX_XLEN-1:0]    reg1;
        logic [`EX_XLEN-1:0]    reg2;
        logic [`EX_XLEN-1:0]    imm;
        logic [`EX_XLEN-1:0]    pc;
        logic [`EX_RADDR_W-1:0] waddr;
        logic                   we;
        logic                   pred_taken; // direction guessed at fetch.
        logic [`EX_XLEN-1:0]    pred_target;
    } ex_req_t;

    typedef struct packed {
        logic                taken;
        logic [`EX_XLEN-1:0] npc;
        logic                mispredict;
        logic [`EX_XLEN-1:0] link;
    } branch_res_t;

    typedef struct packed {
        logic                re;
        logic                we;
        logic [`EX_XLEN-1:0] addr;
        logic [3:0]          sel; // one bit per byte lane.
        logic [`EX_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic ovf;
        logic trap;
        logic adel;
        logic ades;
    } ex_exc_t;

    typedef struct packed {
        logic                   valid;
        logic [`EX_RADDR_W-1:0] waddr;
        logic                   we;
        logic [`EX_XLEN-1:0]    wdata;
        branch_res_t            br;
        mem_req_t               mem;
        ex_exc_t                exc;
    } ex_res_t;

endpackage

`default_nettype wire

/* hdl/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// width of the register file data and of every address in the stage.
`define EX_XLEN 32

// shift amounts come from the low bits of reg1.
`define EX_SHAMT_W 5

`define EX_RADDR_W 5 // register file address width.

// the return address skips the delay slot.
`define EX_LINK_OFFSET 8

`endif
